// ==== verilog.f ====
design/patch_pkg.sv
design/sram_1rw1r.sv
design/query_patch_mem.sv
design/patch_loader.sv
design/wb_query_regs.sv
design/patch_sad.sv
design/query_unit_top.sv
tests/query_unit_tb.sv

// ==== tests/query_unit_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the query unit
// stimulus table of wishbone steps, model of stored patches and the sad,
// bus task and cycle limit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module query_unit_tb;

  localparam int depth = 512;
  localparam logic [1:0] op_wr   = 2'd0;
  localparam logic [1:0] op_rd   = 2'd1;
  localparam logic [1:0] op_poll = 2'd2;  // read reg_start until idle

  typedef struct packed {
    logic [1:0]  op;
    logic [3:0]  adr;
    logic [31:0] dat;
    logic [31:0] exp;
    logic [7:0]  id;
  } step_t;

  logic               clk;
  logic               rst_n;
  patch_pkg::wb_req_t wb;
  logic [31:0]        wb_dat_o;
  logic               wb_ack;

  step_t             steps [256];
  int                n_steps;
  logic [54:0]       model_mem [depth];
  patch_pkg::pixel_t ref_pix [5];
  logic [8:0]        ptr_model;  // expected write counter
  integer            seed;
  int                cycles = 0;
  int                limit = 0;    // 0 until the table is built
  int                errors;
  int                checks;

  query_unit_top #(.depth(depth)) dut_i (.clk, .rst_n, .wb, .wb_dat_o, .wb_ack);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: the table did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic string reg_name(input logic [3:0] adr);
    if (adr >= 4'd2 && adr <= 4'd6) return $sformatf("reg_ref%0d", adr - 4'd2);
    case (adr)
      patch_pkg::reg_pixel:    return "reg_pixel";
      patch_pkg::reg_wr_addr:  return "reg_wr_addr";
      patch_pkg::reg_start:    return "reg_start";
      patch_pkg::reg_sad:      return "reg_sad";
      patch_pkg::reg_rd_addr:  return "reg_rd_addr";
      patch_pkg::reg_patch_lo: return "reg_patch_lo";
      patch_pkg::reg_patch_hi: return "reg_patch_hi";
      default:                 return "unknown";
    endcase
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset values";
      2:       return "write counter";
      3:       return "packing and readback";
      4:       return "bank independence";
      5:       return "sad";
      default: return "masking and ignored start";
    endcase
  endfunction

  // sum of |query pixel - reference pixel|
  function automatic logic [31:0] sad_of(input logic [8:0] addr);
    int sum;
    int q;
    sum = 0;
    for (int i = 0; i < 5; i++) begin
      q = model_mem[addr][11*i +: 11];
      sum += (q > ref_pix[i]) ? q - ref_pix[i] : ref_pix[i] - q;
    end
    return 32'(sum);
  endfunction

  task automatic put_step(input logic [1:0] op, input logic [3:0] adr,
                          input logic [31:0] dat, input logic [31:0] exp, input int id);
    step_t s;
    s = '{op: op, adr: adr, dat: dat, exp: exp, id: 8'(id)};
    steps[n_steps] = s;
    n_steps++;
  endtask

  // five pixels, dirty ones carry bits above 10
  task automatic load_patch(input logic dirty, input int id);
    logic [54:0] flat;
    logic [31:0] raw;
    flat = '0;
    for (int i = 0; i < 5; i++) begin
      raw = $random(seed);
      if (dirty) raw[11] = 1'b1;
      else raw = raw & 32'h7ff;
      flat[11*i +: 11] = raw[10:0];
      put_step(op_wr, patch_pkg::reg_pixel, raw, 0, id);
    end
    model_mem[ptr_model] = flat;
    ptr_model = (ptr_model == 9'(depth - 1)) ? '0 : ptr_model + 1'b1;
  endtask

  task automatic set_ref(input logic dirty, input int id);
    logic [31:0] raw;
    for (int i = 0; i < 5; i++) begin
      raw = $random(seed);
      if (dirty) raw[31] = 1'b1;
      else raw = raw & 32'h7ff;
      ref_pix[i] = raw[10:0];
      put_step(op_wr, patch_pkg::reg_ref0 + 4'(i), raw, 0, id);
    end
  endtask

  task automatic check_patch(input logic [8:0] addr, input int id);
    put_step(op_wr, patch_pkg::reg_rd_addr, 32'(addr), 0, id);
    put_step(op_rd, patch_pkg::reg_patch_lo, 0, model_mem[addr][31:0], id);
    put_step(op_rd, patch_pkg::reg_patch_hi, 0, {9'b0, model_mem[addr][54:32]}, id);
  endtask

  task automatic check_sad(input logic [8:0] addr, input int id);
    put_step(op_wr, patch_pkg::reg_start, 32'(addr), 0, id);
    put_step(op_poll, patch_pkg::reg_start, 0, 0, id);
    put_step(op_rd, patch_pkg::reg_sad, 0, sad_of(addr), id);
  endtask

  // one wishbone classic cycle after an idle cycle
  task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    @(posedge clk);
    #1;
    wb.cyc = 1'b1;
    wb.stb = 1'b1;
    wb.we  = we;
    wb.adr = adr;
    wb.dat = dat;
    @(posedge clk);
    #1;
    while (!wb_ack) begin
      @(posedge clk);
      #1;
    end
    rdata = wb_dat_o;
    @(posedge clk);  // stb held through the ack edge
    #1;
    wb    = '0;
  endtask

  initial begin
    step_t       s;
    logic [31:0] rdata;
    int          t_checks;
    int          t_errors;
    wb        = '0;
    rst_n     = 1'b0;
    seed      = 54;
    n_steps   = 0;
    errors    = 0;
    checks    = 0;
    t_checks  = 0;
    t_errors  = 0;
    ptr_model = '0;

    put_step(op_rd, patch_pkg::reg_start, 0, 0, 1);
    put_step(op_rd, patch_pkg::reg_sad, 0, 0, 1);
    put_step(op_rd, patch_pkg::reg_wr_addr, 0, 0, 1);
    put_step(op_wr, patch_pkg::reg_wr_addr, 32'h0fe, 0, 2);
    ptr_model = 9'h0fe;
    load_patch(1'b0, 2);
    load_patch(1'b0, 2);
    put_step(op_rd, patch_pkg::reg_wr_addr, 0, 32'h100, 2);
    load_patch(1'b0, 3);  // 0x100, upper bank
    load_patch(1'b0, 3);
    for (int a = 'h0fe; a <= 'h101; a++) check_patch(9'(a), 3);
    put_step(op_wr, patch_pkg::reg_wr_addr, 32'h1fe, 0, 4);
    ptr_model = 9'h1fe;
    load_patch(1'b0, 4);
    put_step(op_rd, patch_pkg::reg_wr_addr, 0, 32'h1ff, 4);
    check_patch(9'h0fe, 4);
    check_patch(9'h1fe, 4);
    set_ref(1'b0, 5);
    for (int a = 'h0fe; a <= 'h101; a++) check_sad(9'(a), 5);
    check_sad(9'h1fe, 5);
    put_step(op_wr, patch_pkg::reg_wr_addr, 32'h050, 0, 6);
    ptr_model = 9'h050;
    load_patch(1'b1, 6);
    check_patch(9'h050, 6);
    set_ref(1'b1, 6);
    for (int i = 0; i < 5; i++) begin
      put_step(op_rd, patch_pkg::reg_ref0 + 4'(i), 0, 32'(ref_pix[i]), 6);
    end
    put_step(op_wr, patch_pkg::reg_start, 32'h050, 0, 6);
    put_step(op_wr, patch_pkg::reg_start, 32'h0fe, 0, 6);  // lands while busy
    put_step(op_poll, patch_pkg::reg_start, 0, 0, 6);
    put_step(op_rd, patch_pkg::reg_sad, 0, sad_of(9'h050), 6);

    limit = n_steps * 8 + 100;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int i = 0; i < n_steps; i++) begin
      s = steps[i];
      if (s.op == op_wr) begin
        bus_cycle(1'b1, s.adr, s.dat, rdata);
      end else if (s.op == op_poll) begin
        bus_cycle(1'b0, s.adr, 0, rdata);
        while (rdata[0]) bus_cycle(1'b0, s.adr, 0, rdata);
      end else begin
        bus_cycle(1'b0, s.adr, 0, rdata);
        checks++;
        t_checks++;
        assert (rdata === s.exp) else begin
          $display("[FAIL] test %0d %s: expected %h, got %h",
                   s.id, reg_name(s.adr), s.exp, rdata);
          errors++;
          t_errors++;
        end
      end
      if (i == n_steps - 1 || steps[i+1].id != s.id) begin
        $display("test %0d %s: %0d checks, %0d errors", s.id, test_name(s.id),
                 t_checks, t_errors);
        t_checks = 0;
        t_errors = 0;
      end
    end

    $display("done: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== design/query_unit_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// query unit top level
// wishbone slave, patch loader, patch memory and sad engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module query_unit_top #(
  parameter int depth = 512
) (
  input  logic               clk,
  input  logic               rst_n,
  input  patch_pkg::wb_req_t wb,
  output logic [31:0]        wb_dat_o,
  output logic               wb_ack
);

  logic                          pixel_wr;
  patch_pkg::pixel_t             pixel;
  logic                          set_addr;
  logic [patch_pkg::addr_w-1:0]  new_addr;
  logic [patch_pkg::addr_w-1:0]  wr_ptr;
  patch_pkg::mem_wr_t            ld_wr;
  patch_pkg::mem_wr_t            rd_req;
  patch_pkg::mem_wr_t            mem_req;
  patch_pkg::patch_u             rd0;
  patch_pkg::patch_u             rd1;
  patch_pkg::patch_u             ref_patch;
  logic                          start;
  logic [patch_pkg::addr_w-1:0]  query_addr;
  logic                          rd1_en;
  logic [patch_pkg::addr_w-1:0]  rd1_addr;
  logic                          busy;
  logic [31:0]                   sad;

  // loader write wins port 0
  assign mem_req = ld_wr.en ? ld_wr : rd_req;

  wb_query_regs regs_i (
    .clk, .rst_n, .wb, .wb_dat_o, .wb_ack,
    .pixel_wr, .pixel, .set_addr, .new_addr, .wr_ptr,
    .rd_req, .rd0, .ref_patch, .start, .query_addr, .busy, .sad
  );

  patch_loader #(.depth(depth)) loader_i (
    .clk, .rst_n, .pixel_wr, .pixel, .set_addr, .new_addr, .wr_ptr, .wr(ld_wr)
  );

  query_patch_mem #(.depth(depth)) mem_i (
    .clk, .rst_n, .wr(mem_req), .rd0, .rd1_en, .rd1_addr, .rd1
  );

  // host polls busy, done pulse not needed here
  patch_sad sad_i (
    .clk, .rst_n, .start, .query_addr, .ref_patch,
    .rd_en(rd1_en), .rd_addr(rd1_addr), .rd1, .busy, .done(), .sad
  );

endmodule

// ==== design/patch_sad.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sum of absolute differences engine
// query patch read over memory port 1, compared against the reference
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module patch_sad (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic [patch_pkg::addr_w-1:0]  query_addr,
  input  patch_pkg::patch_u             ref_patch,
  output logic                          rd_en,
  output logic [patch_pkg::addr_w-1:0]  rd_addr,
  input  patch_pkg::patch_u             rd1,
  output logic                          busy,
  output logic                          done,
  output logic [31:0]                   sad
);

  // 5 x 2047 fits in 14 bits
  localparam int sum_w = patch_pkg::pix_w + 3;

  logic                                          accept;
  logic [2:0]                                    stage_v;  // read, diff, sum
  patch_pkg::pixel_t [patch_pkg::patch_pix-1:0]  diff_q;
  logic [sum_w-1:0]                              sum_d;
  logic [sum_w-1:0]                              sum_q;

  assign busy    = |stage_v;
  assign accept  = start && !busy;
  assign rd_en   = accept;
  assign rd_addr = query_addr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_v <= '0;
      done    <= 1'b0;
      sad     <= '0;
    end else begin
      stage_v <= {stage_v[1:0], accept};
      done    <= stage_v[2];
      if (stage_v[2]) sad <= 32'(sum_q);  // held until the next done
    end
  end

  always_ff @(posedge clk) begin
    if (stage_v[0]) begin
      for (int i = 0; i < patch_pkg::patch_pix; i++) begin
        diff_q[i] <= (rd1.pix[i] > ref_patch.pix[i]) ? rd1.pix[i] - ref_patch.pix[i]
                                                     : ref_patch.pix[i] - rd1.pix[i];
      end
    end
    if (stage_v[1]) sum_q <= sum_d;
  end

  always_comb begin
    sum_d = '0;
    for (int i = 0; i < patch_pkg::patch_pix; i++) begin
      sum_d = sum_d + sum_w'(diff_q[i]);
    end
  end

endmodule

// ==== design/wb_query_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave for the query unit
// register decode, reference patch, patch readback and sad start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module wb_query_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  patch_pkg::wb_req_t            wb,
  output logic [31:0]                   wb_dat_o,
  output logic                          wb_ack,
  output logic                          pixel_wr,
  output patch_pkg::pixel_t             pixel,
  output logic                          set_addr,
  output logic [patch_pkg::addr_w-1:0]  new_addr,
  input  logic [patch_pkg::addr_w-1:0]  wr_ptr,
  output patch_pkg::mem_wr_t            rd_req,
  input  patch_pkg::patch_u             rd0,
  output patch_pkg::patch_u             ref_patch,
  output logic                          start,
  output logic [patch_pkg::addr_w-1:0]  query_addr,
  input  logic                          busy,
  input  logic [31:0]                   sad
);

  logic                          req;       // request not yet answered
  logic                          wr_stb;
  logic                          is_patch;
  logic                          rb_pend;   // waiting on memory port 0
  logic                          ack_next;
  logic [patch_pkg::addr_w-1:0]  rd_addr_q;
  logic [31:0]                   rd_mux;

  assign req      = wb.cyc && wb.stb && !wb_ack && !rb_pend;
  assign wr_stb   = req && wb.we;
  assign is_patch = !wb.we &&
                    (wb.adr == patch_pkg::reg_patch_lo || wb.adr == patch_pkg::reg_patch_hi);
  assign ack_next = (req && !is_patch) || rb_pend;

  // port-0 read goes out in the first bus cycle
  always_comb begin
    rd_req      = '0;
    rd_req.en   = req && is_patch;
    rd_req.addr = rd_addr_q;
  end

  always_comb begin
    rd_mux = '0;
    case (wb.adr)
      patch_pkg::reg_wr_addr:  rd_mux[patch_pkg::addr_w-1:0] = wr_ptr;
      patch_pkg::reg_start:    rd_mux[0] = busy;
      patch_pkg::reg_sad:      rd_mux = sad;
      patch_pkg::reg_rd_addr:  rd_mux[patch_pkg::addr_w-1:0] = rd_addr_q;
      patch_pkg::reg_patch_lo: rd_mux = rd0.flat[31:0];
      patch_pkg::reg_patch_hi: rd_mux[patch_pkg::patch_w-33:0] = rd0.flat[patch_pkg::patch_w-1:32];
      default: ;
    endcase
    for (int i = 0; i < patch_pkg::patch_pix; i++) begin
      if (wb.adr == patch_pkg::reg_ref0 + 4'(i)) rd_mux[patch_pkg::pix_w-1:0] = ref_patch.pix[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      rb_pend   <= 1'b0;
      pixel_wr  <= 1'b0;
      set_addr  <= 1'b0;
      start     <= 1'b0;
      rd_addr_q <= '0;
      ref_patch <= '0;
    end else begin
      wb_ack   <= ack_next;
      rb_pend  <= req && is_patch;
      pixel_wr <= wr_stb && wb.adr == patch_pkg::reg_pixel;
      set_addr <= wr_stb && wb.adr == patch_pkg::reg_wr_addr;
      start    <= wr_stb && wb.adr == patch_pkg::reg_start;   // sad drops it when busy
      if (wr_stb && wb.adr == patch_pkg::reg_rd_addr) rd_addr_q <= wb.dat[patch_pkg::addr_w-1:0];
      for (int i = 0; i < patch_pkg::patch_pix; i++) begin
        if (wr_stb && wb.adr == patch_pkg::reg_ref0 + 4'(i)) begin
          ref_patch.pix[i] <= wb.dat[patch_pkg::pix_w-1:0];  // upper bits dropped
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_stb) begin
      pixel      <= wb.dat[patch_pkg::pix_w-1:0];
      new_addr   <= wb.dat[patch_pkg::addr_w-1:0];
      query_addr <= wb.dat[patch_pkg::addr_w-1:0];
    end
    if (ack_next) wb_dat_o <= rd_mux;
  end

endmodule

// ==== design/patch_loader.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// patch loader
// packs five pixels into a patch and writes it at the write pointer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module patch_loader #(
  parameter int depth = 512
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          pixel_wr,
  input  patch_pkg::pixel_t             pixel,
  input  logic                          set_addr,
  input  logic [patch_pkg::addr_w-1:0]  new_addr,
  output logic [patch_pkg::addr_w-1:0]  wr_ptr,
  output patch_pkg::mem_wr_t            wr
);

  logic [2:0]                     pix_idx;
  logic                           last_pix;
  patch_pkg::patch_u              shift_q;
  patch_pkg::patch_u              shift_next;
  logic                           wr_en_q;
  logic [patch_pkg::addr_w-1:0]   wr_addr_q;
  patch_pkg::patch_u              wr_data_q;

  assign last_pix = pixel_wr && pix_idx == 3'(patch_pkg::patch_pix - 1);

  // new pixel enters at the top, pixel 0 ends up in the lsbs
  assign shift_next.flat = {pixel, shift_q.flat[patch_pkg::patch_w-1:patch_pkg::pix_w]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_idx <= '0;
      wr_ptr  <= '0;
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= last_pix;
      if (set_addr) begin
        wr_ptr  <= new_addr;
        pix_idx <= '0;
      end else if (last_pix) begin
        pix_idx <= '0;
        wr_ptr  <= (wr_ptr == patch_pkg::addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end else if (pixel_wr) begin
        pix_idx <= pix_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pixel_wr) shift_q <= shift_next;
    if (last_pix) begin
      wr_addr_q <= wr_ptr;     // pointer before the increment
      wr_data_q <= shift_next;
    end
  end

  always_comb begin
    wr.en   = wr_en_q;
    wr.we   = wr_en_q;
    wr.addr = wr_addr_q;
    wr.data = wr_data_q;
  end

endmodule

// ==== design/query_patch_mem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banked query patch memory
// two sram macros per bank, bank picked by the address msb,
// read data muxed by the bank registered with the access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module query_patch_mem #(
  parameter int depth = 512
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  patch_pkg::mem_wr_t            wr,
  output patch_pkg::patch_u             rd0,
  input  logic                          rd1_en,
  input  logic [patch_pkg::addr_w-1:0]  rd1_addr,
  output patch_pkg::patch_u             rd1
);

  localparam int banks  = depth / 256;
  localparam int bank_w = patch_pkg::addr_w - 8;
  localparam int hi_w   = patch_pkg::patch_w - 32;  // bits kept in the upper macro

  logic [bank_w-1:0] bank0;
  logic [bank_w-1:0] bank1;
  logic [bank_w-1:0] bank0_q;
  logic [bank_w-1:0] bank1_q;
  logic [31:0]       hi_din;
  logic [31:0]       lo0 [banks];
  logic [31:0]       hi0 [banks];
  logic [31:0]       lo1 [banks];
  logic [31:0]       hi1 [banks];

  assign bank0  = wr.addr[patch_pkg::addr_w-1 -: bank_w];
  assign bank1  = rd1_addr[patch_pkg::addr_w-1 -: bank_w];
  assign hi_din = {{(32 - hi_w){1'b0}}, wr.data.flat[patch_pkg::patch_w-1:32]};

  for (genvar b = 0; b < banks; b++) begin : g_bank
    logic csb0;
    logic web0;
    logic csb1;

    assign csb0 = !(wr.en && bank0 == bank_w'(b));
    assign web0 = !wr.we;
    assign csb1 = !(rd1_en && bank1 == bank_w'(b));

    sram_1rw1r lo_i (
      .clk   (clk),
      .csb0  (csb0),
      .web0  (web0),
      .addr0 (wr.addr[7:0]),
      .din0  (wr.data.flat[31:0]),
      .dout0 (lo0[b]),
      .csb1  (csb1),
      .addr1 (rd1_addr[7:0]),
      .dout1 (lo1[b])
    );

    sram_1rw1r hi_i (
      .clk   (clk),
      .csb0  (csb0),
      .web0  (web0),
      .addr0 (wr.addr[7:0]),
      .din0  (hi_din),
      .dout0 (hi0[b]),
      .csb1  (csb1),
      .addr1 (rd1_addr[7:0]),
      .dout1 (hi1[b])
    );
  end

  // bank follows the read into the macro output stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank0_q <= '0;
      bank1_q <= '0;
    end else begin
      if (wr.en && !wr.we) bank0_q <= bank0;
      if (rd1_en) bank1_q <= bank1;
    end
  end

  assign rd0.flat = {hi0[bank0_q][hi_w-1:0], lo0[bank0_q]};
  assign rd1.flat = {hi1[bank1_q][hi_w-1:0], lo1[bank1_q]};

endmodule

// ==== design/sram_1rw1r.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral 32x256 sram macro
// port 0 read or write, port 1 read only, active low controls
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sram_1rw1r (
  input  logic        clk,
  input  logic        csb0,   // port 0 select, active low
  input  logic        web0,   // port 0 write enable, active low
  input  logic [7:0]  addr0,
  input  logic [31:0] din0,
  output logic [31:0] dout0,
  input  logic        csb1,   // port 1 select, active low
  input  logic [7:0]  addr1,
  output logic [31:0] dout1
);

  logic [31:0] mem [256];

  // port 0
  always_ff @(posedge clk) begin
    if (!csb0) begin
      if (!web0) begin
        mem[addr0] <= din0;
      end else begin
        dout0 <= mem[addr0];  // valid the cycle after the select
      end
    end
  end

  // port 1 sees old data on a same-address write
  always_ff @(posedge clk) begin
    if (!csb1) begin
      dout1 <= mem[addr1];
    end
  end

endmodule

// ==== design/patch_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the query patch subsystem
// pixel and patch widths, the patch union, wishbone and port-0 requests
// and the register word addresses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package patch_pkg;

  localparam int pix_w     = 11;
  localparam int patch_pix = 5;
  localparam int patch_w   = pix_w * patch_pix; // 55 bits
  localparam int addr_w    = 9;                 // 512 patches

  typedef logic [pix_w-1:0] pixel_t;

  // one stored patch, flat for the memory, per pixel for the sad
  typedef union packed {
    logic [patch_w-1:0]     flat;
    pixel_t [patch_pix-1:0] pix;  // pix[0] in the lsbs
  } patch_u;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;   // word address
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              en;    // select
    logic              we;    // write enable
    logic [addr_w-1:0] addr;
    patch_u            data;
  } mem_wr_t;

  // register word addresses
  localparam logic [3:0] reg_pixel    = 4'd0;
  localparam logic [3:0] reg_wr_addr  = 4'd1;
  localparam logic [3:0] reg_ref0     = 4'd2;  // ref pixels 0..4 at 2..6
  localparam logic [3:0] reg_start    = 4'd7;
  localparam logic [3:0] reg_sad      = 4'd8;
  localparam logic [3:0] reg_rd_addr  = 4'd9;
  localparam logic [3:0] reg_patch_lo = 4'd10;
  localparam logic [3:0] reg_patch_hi = 4'd11;

endpackage
